// File: Makefile
# Verilator build and run of the CSR and CLINT testbench

VERILATOR ?= verilator
TOP       ?= csr_and_clint_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Regression passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: build.f
rtl/csr_bus_pkg.sv
rtl/csr_map_pkg.sv
rtl/csr_decode.sv
rtl/csr_regfile.sv
rtl/csr_response.sv
rtl/csr_and_clint.sv
verification/tb_clock_gen.sv
verification/csr_and_clint_asserts.sv
verification/csr_and_clint_tb.sv

// File: rtl/csr_and_clint.sv
`timescale 1ns/10ps

module csr_and_clint
  import csr_bus_pkg::*;
  import csr_map_pkg::*;
#(
  parameter int TIMER_DIV = 1
) (
  input  logic              CLK_I,
  input  logic              RST_I,
  input  logic [BUS_AW-1:0] ADR_I,
  input  logic [BUS_DW-1:0] DAT_I,
  input  logic              CYC_I,
  input  logic              STB_I,
  input  logic              WE_I,
  input  logic [3:0]        SEL_I,
  output logic [BUS_DW-1:0] DAT_O,
  output logic              ACK_O,
  output logic [7:0]        leds,
  output logic              timer_irq
);

  // decode to regfile
  logic              req_valid;
  bus_op_e           req_op;
  csr_reg_e          req_reg;
  logic [BUS_DW-1:0] req_wdata;
  logic              req_wen_lane0;

  // regfile to response
  logic              rsp_valid;
  logic [BUS_DW-1:0] rsp_rdata;

  csr_decode i_decode (
    .CLK_I         (CLK_I),
    .RST_I         (RST_I),
    .ADR_I         (ADR_I),
    .DAT_I         (DAT_I),
    .CYC_I         (CYC_I),
    .STB_I         (STB_I),
    .WE_I          (WE_I),
    .SEL_I         (SEL_I),
    .req_valid     (req_valid),
    .req_op        (req_op),
    .req_reg       (req_reg),
    .req_wdata     (req_wdata),
    .req_wen_lane0 (req_wen_lane0)
  );

  csr_regfile #(
    .TIMER_DIV (TIMER_DIV)
  ) i_regfile (
    .CLK_I         (CLK_I),
    .RST_I         (RST_I),
    .req_valid     (req_valid),
    .req_op        (req_op),
    .req_reg       (req_reg),
    .req_wdata     (req_wdata),
    .req_wen_lane0 (req_wen_lane0),
    .rsp_valid     (rsp_valid),
    .rsp_rdata     (rsp_rdata),
    .leds          (leds),
    .timer_irq     (timer_irq)
  );

  csr_response i_response (
    .CLK_I     (CLK_I),
    .RST_I     (RST_I),
    .rsp_valid (rsp_valid),
    .rsp_rdata (rsp_rdata),
    .ACK_O     (ACK_O),
    .DAT_O     (DAT_O)
  );

endmodule

// File: rtl/csr_bus_pkg.sv
package csr_bus_pkg;

  // wishbone address and data widths
  localparam int BUS_AW = 32;
  localparam int BUS_DW = 32;

  // access kind, taken from WE_I
  typedef enum logic {
    BUS_READ  = 1'b0,
    BUS_WRITE = 1'b1
  } bus_op_e;

endpackage

// File: rtl/csr_decode.sv
`timescale 1ns/10ps

module csr_decode
  import csr_bus_pkg::*;
  import csr_map_pkg::*;
(
  input  logic              CLK_I,
  input  logic              RST_I,
  input  logic [BUS_AW-1:0] ADR_I,
  input  logic [BUS_DW-1:0] DAT_I,
  input  logic              CYC_I,
  input  logic              STB_I,
  input  logic              WE_I,
  input  logic [3:0]        SEL_I,
  output logic              req_valid,
  output bus_op_e           req_op,
  output csr_reg_e          req_reg,
  output logic [BUS_DW-1:0] req_wdata,
  output logic              req_wen_lane0
);

  // low address bits give the offset inside a window
  localparam logic [BUS_AW-1:0] OFS_MASK = BUS_AW'(WINDOW_SIZE - 1);

  logic req_hit;

  function automatic logic in_window(input logic [BUS_AW-1:0] adr,
                                     input logic [BUS_AW-1:0] base);
    in_window = adr[BUS_AW-1:WINDOW_LSB] == base[BUS_AW-1:WINDOW_LSB];
  endfunction

  function automatic logic at_offset(input logic [BUS_AW-1:0] adr,
                                     input logic [BUS_AW-1:0] reg_adr);
    at_offset = (adr & OFS_MASK) == (reg_adr & OFS_MASK);
  endfunction

  // uart and ethernet windows fall through to REG_NONE
  function automatic csr_reg_e decode_reg(input logic [BUS_AW-1:0] adr);
    csr_reg_e sel;
    sel = REG_NONE;
    if (in_window(adr, CTRL_BASE)) begin
      if (at_offset(adr, ADR_CTRL_RESET)) begin
        sel = REG_CTRL_RESET;
      end else if (at_offset(adr, ADR_CTRL_SCRATCH)) begin
        sel = REG_CTRL_SCRATCH;
      end else if (at_offset(adr, ADR_CTRL_BUS_ERRORS)) begin
        sel = REG_CTRL_BUS_ERRORS;
      end
    end else if (in_window(adr, LEDS_BASE)) begin
      if (at_offset(adr, ADR_LEDS_OUT)) begin
        sel = REG_LEDS_OUT;
      end
    end else if (in_window(adr, CLINT_BASE)) begin
      if (at_offset(adr, ADR_MTIME)) begin
        sel = REG_MTIME;
      end else if (at_offset(adr, ADR_MTIMECMP)) begin
        sel = REG_MTIMECMP;
      end
    end
    return sel;
  endfunction

  // pipelined mode, every strobed cycle is a new request
  assign req_hit = CYC_I & STB_I;

  always_ff @(posedge CLK_I or posedge RST_I) begin
    if (RST_I) begin
      req_valid <= 1'b0;
    end else begin
      req_valid <= req_hit;
    end
  end

  always_ff @(posedge CLK_I) begin
    if (req_hit) begin
      req_op        <= WE_I ? BUS_WRITE : BUS_READ;
      req_reg       <= decode_reg(ADR_I);
      req_wdata     <= DAT_I;
      // only byte lane 0 carries register data
      req_wen_lane0 <= SEL_I[0];
    end
  end

endmodule

// File: rtl/csr_map_pkg.sv
package csr_map_pkg;

  // each peripheral owns a 2 KB window
  localparam int WINDOW_LSB = 11;
  localparam int unsigned WINDOW_SIZE = 1 << WINDOW_LSB;

  // window bases
  localparam logic [31:0] CTRL_BASE  = 32'hF000_0000;
  localparam logic [31:0] LEDS_BASE  = 32'hF000_3800;
  localparam logic [31:0] CLINT_BASE = 32'hF000_4000;

  // ctrl block
  localparam logic [31:0] ADR_CTRL_RESET      = CTRL_BASE + 32'h0;
  localparam logic [31:0] ADR_CTRL_SCRATCH    = CTRL_BASE + 32'h4;
  localparam logic [31:0] ADR_CTRL_BUS_ERRORS = CTRL_BASE + 32'h8;

  // leds block
  localparam logic [31:0] ADR_LEDS_OUT = LEDS_BASE + 32'h0;

  // core-local timer
  localparam logic [31:0] ADR_MTIME    = CLINT_BASE + 32'h0;
  localparam logic [31:0] ADR_MTIMECMP = CLINT_BASE + 32'h4;

  // register selected by a decoded request
  typedef enum logic [2:0] {
    REG_CTRL_RESET      = 3'd0,
    REG_CTRL_SCRATCH    = 3'd1,
    REG_CTRL_BUS_ERRORS = 3'd2,
    REG_LEDS_OUT        = 3'd3,
    REG_MTIME           = 3'd4,
    REG_MTIMECMP        = 3'd5,
    REG_NONE            = 3'd7
  } csr_reg_e;

endpackage

// File: rtl/csr_regfile.sv
`timescale 1ns/10ps

module csr_regfile
  import csr_bus_pkg::*;
  import csr_map_pkg::*;
#(
  parameter int TIMER_DIV = 1
) (
  input  logic              CLK_I,
  input  logic              RST_I,
  input  logic              req_valid,
  input  bus_op_e           req_op,
  input  csr_reg_e          req_reg,
  input  logic [BUS_DW-1:0] req_wdata,
  input  logic              req_wen_lane0,
  output logic              rsp_valid,
  output logic [BUS_DW-1:0] rsp_rdata,
  output logic [7:0]        leds,
  output logic              timer_irq
);

  localparam int PRE_W = (TIMER_DIV > 1) ? $clog2(TIMER_DIV) : 1;
  localparam logic [PRE_W-1:0] PRE_LAST = PRE_W'(TIMER_DIV - 1);

  logic [7:0]        ctrl_reset;
  logic [7:0]        ctrl_scratch;
  logic [7:0]        ctrl_bus_errors;
  logic [7:0]        leds_out;
  logic [BUS_DW-1:0] mtime;
  logic [BUS_DW-1:0] mtimecmp;
  logic [PRE_W-1:0]  prescale;
  logic              tick;
  logic              wr_en;
  logic [BUS_DW-1:0] rd_data;

  function automatic logic [BUS_DW-1:0] zext8(input logic [7:0] val);
    zext8 = {{(BUS_DW - 8){1'b0}}, val};
  endfunction

  assign wr_en = req_valid && (req_op == BUS_WRITE) && req_wen_lane0;
  assign leds  = leds_out;

  // read mux sees the value before this cycle's write
  always_comb begin
    case (req_reg)
      REG_CTRL_RESET:      rd_data = zext8(ctrl_reset);
      REG_CTRL_SCRATCH:    rd_data = zext8(ctrl_scratch);
      REG_CTRL_BUS_ERRORS: rd_data = zext8(ctrl_bus_errors);
      REG_LEDS_OUT:        rd_data = zext8(leds_out);
      REG_MTIME:           rd_data = mtime;
      REG_MTIMECMP:        rd_data = mtimecmp;
      default:             rd_data = '0;
    endcase
  end

  // read-write registers, bus_errors and mtime ignore writes
  always_ff @(posedge CLK_I or posedge RST_I) begin
    if (RST_I) begin
      ctrl_reset   <= 8'h00;
      ctrl_scratch <= 8'h00;
      leds_out     <= 8'h00;
      mtimecmp     <= '1;
    end else if (wr_en) begin
      case (req_reg)
        REG_CTRL_RESET:   ctrl_reset   <= req_wdata[7:0];
        REG_CTRL_SCRATCH: ctrl_scratch <= req_wdata[7:0];
        REG_LEDS_OUT:     leds_out     <= req_wdata[7:0];
        REG_MTIMECMP:     mtimecmp     <= req_wdata;
        default: begin
        end
      endcase
    end
  end

  // unmapped accesses, saturating at 255
  always_ff @(posedge CLK_I or posedge RST_I) begin
    if (RST_I) begin
      ctrl_bus_errors <= 8'h00;
    end else if (req_valid && (req_reg == REG_NONE) && (ctrl_bus_errors != 8'hFF)) begin
      ctrl_bus_errors <= ctrl_bus_errors + 8'd1;
    end
  end

  // mtime prescaler
  assign tick = (prescale == PRE_LAST);

  always_ff @(posedge CLK_I or posedge RST_I) begin
    if (RST_I) begin
      prescale <= '0;
      mtime    <= '0;
    end else begin
      prescale <= tick ? '0 : prescale + 1'b1;
      if (tick) begin
        mtime <= mtime + 1'b1;
      end
    end
  end

  // one cycle behind the compare
  always_ff @(posedge CLK_I or posedge RST_I) begin
    if (RST_I) begin
      timer_irq <= 1'b0;
    end else begin
      timer_irq <= (mtime >= mtimecmp);
    end
  end

  always_ff @(posedge CLK_I or posedge RST_I) begin
    if (RST_I) begin
      rsp_valid <= 1'b0;
    end else begin
      rsp_valid <= req_valid;
    end
  end

  always_ff @(posedge CLK_I) begin
    if (req_valid) begin
      rsp_rdata <= rd_data;
    end
  end

endmodule

// File: rtl/csr_response.sv
`timescale 1ns/10ps

module csr_response
  import csr_bus_pkg::*;
(
  input  logic              CLK_I,
  input  logic              RST_I,
  input  logic              rsp_valid,
  input  logic [BUS_DW-1:0] rsp_rdata,
  output logic              ACK_O,
  output logic [BUS_DW-1:0] DAT_O
);

  // one ack per response, held for a single cycle
  always_ff @(posedge CLK_I or posedge RST_I) begin
    if (RST_I) begin
      ACK_O <= 1'b0;
    end else begin
      ACK_O <= rsp_valid;
    end
  end

  // data bus idles at zero between acks
  always_ff @(posedge CLK_I or posedge RST_I) begin
    if (RST_I) begin
      DAT_O <= '0;
    end else if (rsp_valid) begin
      DAT_O <= rsp_rdata;
    end else begin
      DAT_O <= '0;
    end
  end

endmodule

// File: verification/csr_and_clint_asserts.sv
`timescale 1ns/10ps

module csr_and_clint_asserts (
  input logic CLK_I,
  input logic RST_I,
  input logic CYC_I,
  input logic STB_I,
  input logic ACK_O,
  input logic timer_irq
);

  // fixed three-edge latency, no back-pressure
  ack_follows_req: assert property (@(posedge CLK_I) disable iff (RST_I)
    $past(CYC_I && STB_I, 3) |-> ACK_O)
    else $error("request was not acknowledged three cycles later");

  ack_has_req: assert property (@(posedge CLK_I) disable iff (RST_I)
    ACK_O |-> $past(CYC_I && STB_I, 3))
    else $error("acknowledge without a matching request");

  // outputs stay quiet while reset is held
  quiet_in_reset: assert property (@(posedge CLK_I)
    RST_I |-> (!ACK_O && !timer_irq))
    else $error("ACK_O or timer_irq high during reset");

endmodule

bind csr_and_clint csr_and_clint_asserts i_asserts (
  .CLK_I     (CLK_I),
  .RST_I     (RST_I),
  .CYC_I     (CYC_I),
  .STB_I     (STB_I),
  .ACK_O     (ACK_O),
  .timer_irq (timer_irq)
);

// File: verification/csr_and_clint_tb.sv
`timescale 1ns/10ps

module csr_and_clint_tb
  import csr_bus_pkg::*;
  import csr_map_pkg::*;
();

  // request counts per phase
  localparam int N_RESET = 5;
  localparam int N_RW    = 32;
  localparam int N_RO    = 3;
  localparam int N_UNMAP = 260;
  localparam int N_TIME  = 4;
  localparam int N_IRQ   = 2;
  localparam int N_B2B   = 64;
  localparam int TOTAL_REQ = N_RESET + 2 * N_RW + N_RO + N_UNMAP + 1 + N_TIME + N_IRQ + N_B2B;
  localparam int CYCLE_LIMIT = TOTAL_REQ * 6 + 400;

  // what the compare process does with an acknowledge
  localparam int K_DATA = 0;
  localparam int K_NONE = 1;
  localparam int K_TIME = 2;

  logic              CLK_I;
  logic              RST_I;
  logic [BUS_AW-1:0] ADR_I;
  logic [BUS_DW-1:0] DAT_I;
  logic              CYC_I;
  logic              STB_I;
  logic              WE_I;
  logic [3:0]        SEL_I;
  logic [BUS_DW-1:0] DAT_O;
  logic              ACK_O;
  logic [7:0]        leds;
  logic              timer_irq;

  integer            seed = 32'he679;
  int                cycle_cnt = 0;
  int                run_edges = 0;
  int                data_errors = 0;
  int                irq_errors = 0;
  int                leds_errors = 0;
  int                proto_errors = 0;
  int                kind_q[$];
  logic [BUS_DW-1:0] exp_q[$];
  logic [BUS_DW-1:0] time_q[$];
  int                ack_kind;
  logic [BUS_DW-1:0] ack_exp;

  // reference register state
  logic [7:0]        m_ctrl_reset;
  logic [7:0]        m_scratch;
  logic [7:0]        m_bus_errors;
  logic [7:0]        m_leds;
  logic [BUS_DW-1:0] m_mtimecmp;

  tb_clock_gen i_clk (
    .CLK_I (CLK_I),
    .RST_I (RST_I)
  );

  csr_and_clint #(
    .TIMER_DIV (1)
  ) i_dut (
    .CLK_I     (CLK_I),
    .RST_I     (RST_I),
    .ADR_I     (ADR_I),
    .DAT_I     (DAT_I),
    .CYC_I     (CYC_I),
    .STB_I     (STB_I),
    .WE_I      (WE_I),
    .SEL_I     (SEL_I),
    .DAT_O     (DAT_O),
    .ACK_O     (ACK_O),
    .leds      (leds),
    .timer_irq (timer_irq)
  );

  // full address match against the register map
  function automatic csr_reg_e reg_of(input logic [BUS_AW-1:0] adr);
    case (adr)
      ADR_CTRL_RESET:      return REG_CTRL_RESET;
      ADR_CTRL_SCRATCH:    return REG_CTRL_SCRATCH;
      ADR_CTRL_BUS_ERRORS: return REG_CTRL_BUS_ERRORS;
      ADR_LEDS_OUT:        return REG_LEDS_OUT;
      ADR_MTIME:           return REG_MTIME;
      ADR_MTIMECMP:        return REG_MTIMECMP;
      default:             return REG_NONE;
    endcase
  endfunction

  // returns the value a read sees, then applies a write
  function automatic logic [BUS_DW-1:0] csr_model(input bus_op_e op,
                                                  input logic [BUS_AW-1:0] adr,
                                                  input logic [BUS_DW-1:0] data,
                                                  input logic lane);
    csr_reg_e          r;
    logic [BUS_DW-1:0] rd;
    r = reg_of(adr);
    case (r)
      REG_CTRL_RESET:      rd = {24'h0, m_ctrl_reset};
      REG_CTRL_SCRATCH:    rd = {24'h0, m_scratch};
      REG_CTRL_BUS_ERRORS: rd = {24'h0, m_bus_errors};
      REG_LEDS_OUT:        rd = {24'h0, m_leds};
      REG_MTIMECMP:        rd = m_mtimecmp;
      default:             rd = '0;
    endcase
    if (r == REG_NONE && m_bus_errors != 8'd255) begin
      m_bus_errors = m_bus_errors + 8'd1;
    end
    if (op == BUS_WRITE && lane) begin
      case (r)
        REG_CTRL_RESET:   m_ctrl_reset = data[7:0];
        REG_CTRL_SCRATCH: m_scratch = data[7:0];
        REG_LEDS_OUT:     m_leds = data[7:0];
        REG_MTIMECMP:     m_mtimecmp = data;
        default: begin
        end
      endcase
    end
    return rd;
  endfunction

  function automatic logic [BUS_AW-1:0] rw_adr(input int idx);
    case (idx)
      0:       return ADR_CTRL_RESET;
      1:       return ADR_CTRL_SCRATCH;
      2:       return ADR_LEDS_OUT;
      default: return ADR_MTIMECMP;
    endcase
  endfunction

  // holes in the map including the uart and ethernet windows
  function automatic logic [BUS_AW-1:0] hole_adr(input int idx);
    case (idx % 6)
      0:       return CTRL_BASE + 32'h0C;
      1:       return CTRL_BASE + 32'h800;
      2:       return 32'hF000_1000;
      3:       return 32'hF000_2000;
      4:       return LEDS_BASE + 32'h4;
      default: return CLINT_BASE + 32'h8;
    endcase
  endfunction

  task automatic check_rdata(input logic [BUS_DW-1:0] got, input logic [BUS_DW-1:0] exp,
                             input string what);
    if (got !== exp) begin
      data_errors++;
      $display("ERR %0t: %s got 0x%08h, expected 0x%08h", $time, what, got, exp);
    end
  endtask

  task automatic check_irq(input logic got, input logic exp);
    if (got !== exp) begin
      irq_errors++;
      $display("ERR %0t: timer_irq is %b, expected %b", $time, got, exp);
    end
  endtask

  task automatic check_leds(input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      leds_errors++;
      $display("ERR %0t: leds is 0x%02h, expected 0x%02h", $time, got, exp);
    end
  endtask

  // one strobed cycle; leaves the bus idle unless the next call follows
  task automatic bus_request(input bus_op_e op, input logic [BUS_AW-1:0] adr,
                             input logic [BUS_DW-1:0] data, input logic [3:0] sel);
    csr_reg_e r;
    r = reg_of(adr);
    exp_q.push_back(csr_model(op, adr, data, sel[0]));
    if (r == REG_MTIME && op == BUS_READ) begin
      kind_q.push_back(K_TIME);
    end else if (op == BUS_READ || r == REG_NONE) begin
      kind_q.push_back(K_DATA);
    end else begin
      kind_q.push_back(K_NONE);
    end
    CYC_I = 1'b1;
    STB_I = 1'b1;
    WE_I  = (op == BUS_WRITE);
    ADR_I = adr;
    DAT_I = data;
    SEL_I = sel;
    @(posedge CLK_I);
    #10;
    CYC_I = 1'b0;
    STB_I = 1'b0;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge CLK_I);
      #10;
    end
  endtask

  task automatic wait_drain();
    while (kind_q.size() != 0) begin
      @(posedge CLK_I);
      #10;
    end
  endtask

  task automatic mtime_gap(input int d);
    time_q.delete();
    bus_request(BUS_READ, ADR_MTIME, '0, 4'hF);
    idle(d - 1);
    bus_request(BUS_READ, ADR_MTIME, '0, 4'hF);
    wait_drain();
    if (time_q.size() != 2) begin
      proto_errors++;
      $display("expected two mtime read responses, saw %0d", time_q.size());
    end else begin
      check_rdata(time_q[1] - time_q[0], BUS_DW'(d), "mtime delta");
    end
  endtask

  task automatic print_counts();
    $display("errors: data %0d, irq %0d, leds %0d, protocol %0d",
             data_errors, irq_errors, leds_errors, proto_errors);
  endtask

  // DAT_O and ACK_O are stable at the falling edge
  always @(negedge CLK_I) begin
    if (!RST_I && ACK_O) begin
      if (kind_q.size() == 0) begin
        proto_errors++;
        $display("acknowledge at %0t arrived with no request outstanding", $time);
      end else begin
        ack_kind = kind_q.pop_front();
        ack_exp  = exp_q.pop_front();
        if (ack_kind == K_DATA) begin
          check_rdata(DAT_O, ack_exp, "DAT_O");
        end else if (ack_kind == K_TIME) begin
          // mtime counts edges since reset and was read two edges before the ack
          check_rdata(DAT_O, BUS_DW'(run_edges - 2), "mtime");
          time_q.push_back(DAT_O);
        end
      end
    end
  end

  always @(posedge CLK_I) begin
    cycle_cnt++;
    if (!RST_I) begin
      run_edges++;
    end
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("run did not finish within %0d cycles and was stopped", CYCLE_LIMIT);
      print_counts();
      $display("Regression failed");
      $finish;
    end
  end

  initial begin
    logic [BUS_DW-1:0] data;
    logic [BUS_AW-1:0] adr;
    logic [3:0]        sel;
    bus_op_e           op;
    ADR_I = '0;
    DAT_I = '0;
    CYC_I = 1'b0;
    STB_I = 1'b0;
    WE_I  = 1'b0;
    SEL_I = 4'h0;
    m_ctrl_reset = 8'h00;
    m_scratch    = 8'h00;
    m_bus_errors = 8'h00;
    m_leds       = 8'h00;
    m_mtimecmp   = '1;
    @(negedge RST_I);
    idle(1);

    // reset values
    check_leds(leds, 8'h00);
    bus_request(BUS_READ, ADR_CTRL_RESET, '0, 4'hF);
    bus_request(BUS_READ, ADR_CTRL_SCRATCH, '0, 4'hF);
    bus_request(BUS_READ, ADR_CTRL_BUS_ERRORS, '0, 4'hF);
    bus_request(BUS_READ, ADR_LEDS_OUT, '0, 4'hF);
    bus_request(BUS_READ, ADR_MTIMECMP, '0, 4'hF);
    wait_drain();
    check_irq(timer_irq, 1'b0);

    // random write then read back with a random lane 0 enable
    for (int i = 0; i < N_RW; i++) begin
      adr  = rw_adr($random(seed) & 3);
      data = $random(seed);
      sel  = 4'($random(seed));
      bus_request(BUS_WRITE, adr, data, sel);
      bus_request(BUS_READ, adr, '0, 4'hF);
      wait_drain();
      check_leds(leds, m_leds);
    end

    // read-only registers, then the error counter up to saturation
    data = $random(seed);
    bus_request(BUS_WRITE, ADR_CTRL_BUS_ERRORS, data, 4'hF);
    bus_request(BUS_WRITE, ADR_MTIME, data, 4'hF);
    bus_request(BUS_READ, ADR_CTRL_BUS_ERRORS, '0, 4'hF);
    for (int i = 0; i < N_UNMAP; i++) begin
      if (i % 4 == 0) begin
        adr = hole_adr(i / 4);
      end else begin
        adr = 32'hF000_0800 + ($random(seed) & 32'h2FFF);
      end
      op   = (i % 2 == 1) ? BUS_WRITE : BUS_READ;
      data = $random(seed);
      bus_request(op, adr, data, 4'hF);
    end
    bus_request(BUS_READ, ADR_CTRL_BUS_ERRORS, '0, 4'hF);
    wait_drain();

    // mtime advances one per clock
    mtime_gap(7);
    mtime_gap(1 + ($random(seed) & 15));

    // compare against mtime drives the interrupt
    bus_request(BUS_WRITE, ADR_MTIMECMP, '0, 4'hF);
    wait_drain();
    check_irq(timer_irq, 1'b1);
    bus_request(BUS_WRITE, ADR_MTIMECMP, '1, 4'hF);
    wait_drain();
    check_irq(timer_irq, 1'b0);

    // back-to-back mix of writes and reads
    for (int i = 0; i < N_B2B; i++) begin
      adr  = rw_adr($random(seed) & 3);
      op   = (($random(seed) & 1) != 0) ? BUS_WRITE : BUS_READ;
      data = $random(seed);
      sel  = 4'($random(seed));
      bus_request(op, adr, data, sel);
    end
    wait_drain();
    check_leds(leds, m_leds);

    if (kind_q.size() != 0) begin
      proto_errors++;
      $display("%0d expected responses were never acknowledged", kind_q.size());
    end
    print_counts();
    if (data_errors + irq_errors + leds_errors + proto_errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// File: verification/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen #(
  parameter int HALF_PERIOD = 50,
  parameter int RST_CYCLES  = 3
) (
  output logic CLK_I,
  output logic RST_I
);

  initial begin
    CLK_I = 1'b0;
    forever #(HALF_PERIOD) CLK_I = ~CLK_I;
  end

  // release lines up with the stimulus drive point
  initial begin
    RST_I = 1'b1;
    repeat (RST_CYCLES) @(posedge CLK_I);
    #10;
    RST_I = 1'b0;
  end

endmodule
